/* verification/issue_patterns.txt */
// test dv opc psrc1 psrc2 pdest ctrl free wbv wbpreg fu_rdy (fu 10 = random mask)
// then two cycles later: mul vld slot pdest, alu1 vld slot pdest, alu2 vld slot pdest,
// adr vld slot pdest, full
1 1 0 01 02 10 a1 20 0 00 f  1 0 10  0 0 00  0 0 00  0 0 00  0
1 1 3 03 04 11 b2 21 0 00 f  0 0 00  0 0 00  0 0 00  1 1 11  0
1 1 2 05 06 12 c3 22 0 00 f  0 0 00  1 0 12  0 0 00  0 0 00  0
1 1 1 07 08 13 d4 23 0 00 f  0 0 00  0 0 00  1 1 13  0 0 00  0
1 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
2 1 1 10 02 14 e5 24 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
2 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
2 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
2 0 0 00 00 00 00 00 1 10 f  0 0 00  1 0 14  0 0 00  0 0 00  0
2 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
3 1 0 11 01 15 16 25 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
3 1 0 11 02 16 27 26 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
3 1 0 11 03 17 38 27 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
3 0 0 00 00 00 00 00 1 11 f  1 0 15  0 0 00  0 0 00  0 0 00  0
3 0 0 00 00 00 00 00 0 00 f  1 1 16  0 0 00  0 0 00  0 0 00  0
3 0 0 00 00 00 00 00 0 00 f  1 2 17  0 0 00  0 0 00  0 0 00  0
3 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
4 1 1 12 01 18 41 28 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
4 1 1 12 02 19 52 29 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
4 1 1 12 03 1a 63 2a 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
4 1 1 12 04 1b 74 2b 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
4 1 2 12 05 1c 85 2c 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
4 0 0 00 00 00 00 00 1 12 f  0 0 00  1 0 18  1 1 19  0 0 00  0
4 0 0 00 00 00 00 00 0 00 f  0 0 00  1 3 1b  1 2 1a  0 0 00  0
4 0 0 00 00 00 00 00 0 00 f  0 0 00  1 4 1c  0 0 00  0 0 00  0
4 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
5 1 3 01 02 1d 96 2d 0 00 7  0 0 00  0 0 00  0 0 00  0 0 00  0
5 1 3 03 04 1e a7 2e 0 00 7  0 0 00  0 0 00  0 0 00  0 0 00  0
5 1 0 05 06 1f b8 2f 0 00 7  1 2 1f  0 0 00  0 0 00  0 0 00  0
5 0 0 00 00 00 00 00 0 00 7  0 0 00  0 0 00  0 0 00  0 0 00  0
5 0 0 00 00 00 00 00 0 00 7  0 0 00  0 0 00  0 0 00  1 0 1d  0
5 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  1 1 1e  0
5 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
6 1 0 01 02 20 e0 30 0 00 0  0 0 00  0 0 00  0 0 00  0 0 00  0
6 1 1 01 02 21 e1 31 0 00 0  0 0 00  0 0 00  0 0 00  0 0 00  0
6 1 2 01 02 22 e2 32 0 00 0  0 0 00  0 0 00  0 0 00  0 0 00  0
6 1 3 01 02 23 e3 33 0 00 0  0 0 00  0 0 00  0 0 00  0 0 00  0
6 1 0 01 02 24 e4 34 0 00 0  0 0 00  0 0 00  0 0 00  0 0 00  0
6 1 1 01 02 25 e5 35 0 00 0  0 0 00  0 0 00  0 0 00  0 0 00  0
6 1 1 01 02 26 e6 36 0 00 0  0 0 00  0 0 00  0 0 00  0 0 00  1
6 1 3 01 02 27 e7 37 0 00 0  0 0 00  0 0 00  0 0 00  0 0 00  1
6 1 1 01 02 28 e8 38 0 00 0  1 0 20  1 2 22  1 1 21  1 3 23  0
6 0 0 00 00 00 00 00 0 00 f  1 4 24  1 6 26  1 5 25  1 7 27  0
6 0 0 00 00 00 00 00 0 00 f  0 0 00  0 0 00  0 0 00  0 0 00  0
6 0 0 00 00 00 00 00 0 00 10 0 0 00  0 0 00  0 0 00  0 0 00  0
6 0 0 00 00 00 00 00 0 00 10 0 0 00  0 0 00  0 0 00  0 0 00  0
6 0 0 00 00 00 00 00 0 00 10 0 0 00  0 0 00  0 0 00  0 0 00  0

/* project.f */
hdl/issue_pkg.sv
hdl/issue_queue.sv
hdl/operand_scoreboard.sv
hdl/issue_select.sv
hdl/issue_stage_top.sv
verification/tb_clock_gen.sv
verification/tb_issue_stage.sv

/* Bender.yml */
package:
  name: issue_stage

sources:
  - hdl/issue_pkg.sv
  - hdl/issue_queue.sv
  - hdl/operand_scoreboard.sv
  - hdl/issue_select.sv
  - hdl/issue_stage_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_issue_stage.sv

/* verification/tb_issue_stage.sv */
`timescale 1ns/1ns

module tb_issue_stage;
   import issue_pkg::*;

   localparam int ISQ_DEPTH = 8;
   localparam int IDX_BITS  = $clog2(ISQ_DEPTH);
   localparam int PAT_MAX   = 64;

   //////////////////////////////////////////////////
   // pattern row layout with one hex field per column
   //////////////////////////////////////////////////
   localparam int NFIELD = 24;
   localparam int F_TEST = 0;
   localparam int F_DV   = 1;
   localparam int F_OPC  = 2;
   localparam int F_PS1  = 3;
   localparam int F_PS2  = 4;
   localparam int F_PD   = 5;
   localparam int F_CTRL = 6;
   localparam int F_FP   = 7;
   localparam int F_WBV  = 8;
   localparam int F_WBP  = 9;
   localparam int F_FU   = 10;
   // valid, slot and pdest of each unit in unit order
   localparam int F_EXP  = 11;
   localparam int F_FULL = 23;

   logic                 clk;
   logic                 rst;
   logic                 dispatch_vld;
   logic [OPC_BITS-1:0]  opcls;
   logic [PREG_BITS-1:0] psrc1;
   logic [PREG_BITS-1:0] psrc2;
   logic [PREG_BITS-1:0] pdest;
   logic [CTRL_BITS-1:0] ctrl;
   logic [PREG_BITS-1:0] free_preg;
   logic                 wb_vld;
   logic [PREG_BITS-1:0] wb_preg;
   logic [FU_NUM-1:0]    fu_rdy;
   wire                  full;

   // issue ports gathered per unit
   wire [FU_NUM-1:0]                iss_vld;
   wire [FU_NUM-1:0][IDX_BITS-1:0]  iss_idx;
   wire [FU_NUM-1:0][PREG_BITS-1:0] iss_psrc1;
   wire [FU_NUM-1:0][PREG_BITS-1:0] iss_psrc2;
   wire [FU_NUM-1:0][PREG_BITS-1:0] iss_pdest;
   wire [FU_NUM-1:0][CTRL_BITS-1:0] iss_ctrl;
   wire [FU_NUM-1:0][PREG_BITS-1:0] iss_free;

   logic [8:0] pat_mem [PAT_MAX*NFIELD];
   // dispatched fields looked up by pdest when the instruction issues
   logic [PREG_BITS-1:0] rec_psrc1 [PREG_NUM];
   logic [PREG_BITS-1:0] rec_psrc2 [PREG_NUM];
   logic [CTRL_BITS-1:0] rec_ctrl  [PREG_NUM];
   logic [PREG_BITS-1:0] rec_free  [PREG_NUM];

   int npat;
   int err_cnt     = 0;
   int row_cnt     = 0;
   int test_cnt    = 0;
   int test_rows   = 0;
   int test_err    = 0;
   int cycle_cnt   = 0;
   int cycle_limit = PAT_MAX + 20;

   tb_clock_gen #(.PERIOD_NS(100)) u_clk (.clk_o(clk));

   issue_stage_top #(.ISQ_DEPTH(ISQ_DEPTH)) DUT (
      .clk_i            (clk),
      .rst_i            (rst),
      .dispatch_vld_i   (dispatch_vld),
      .opcls_i          (opcls),
      .psrc1_i          (psrc1),
      .psrc2_i          (psrc2),
      .pdest_i          (pdest),
      .ctrl_i           (ctrl),
      .free_preg_i      (free_preg),
      .wb_vld_i         (wb_vld),
      .wb_preg_i        (wb_preg),
      .fu_rdy_i         (fu_rdy),
      .full_o           (full),
      .mul_vld_o        (iss_vld[FU_MULT]),
      .mul_idx_o        (iss_idx[FU_MULT]),
      .mul_psrc1_o      (iss_psrc1[FU_MULT]),
      .mul_psrc2_o      (iss_psrc2[FU_MULT]),
      .mul_pdest_o      (iss_pdest[FU_MULT]),
      .mul_ctrl_o       (iss_ctrl[FU_MULT]),
      .mul_free_preg_o  (iss_free[FU_MULT]),
      .alu1_vld_o       (iss_vld[FU_ALU1]),
      .alu1_idx_o       (iss_idx[FU_ALU1]),
      .alu1_psrc1_o     (iss_psrc1[FU_ALU1]),
      .alu1_psrc2_o     (iss_psrc2[FU_ALU1]),
      .alu1_pdest_o     (iss_pdest[FU_ALU1]),
      .alu1_ctrl_o      (iss_ctrl[FU_ALU1]),
      .alu1_free_preg_o (iss_free[FU_ALU1]),
      .alu2_vld_o       (iss_vld[FU_ALU2]),
      .alu2_idx_o       (iss_idx[FU_ALU2]),
      .alu2_psrc1_o     (iss_psrc1[FU_ALU2]),
      .alu2_psrc2_o     (iss_psrc2[FU_ALU2]),
      .alu2_pdest_o     (iss_pdest[FU_ALU2]),
      .alu2_ctrl_o      (iss_ctrl[FU_ALU2]),
      .alu2_free_preg_o (iss_free[FU_ALU2]),
      .adr_vld_o        (iss_vld[FU_ADDR]),
      .adr_idx_o        (iss_idx[FU_ADDR]),
      .adr_psrc1_o      (iss_psrc1[FU_ADDR]),
      .adr_psrc2_o      (iss_psrc2[FU_ADDR]),
      .adr_pdest_o      (iss_pdest[FU_ADDR]),
      .adr_ctrl_o       (iss_ctrl[FU_ADDR]),
      .adr_free_preg_o  (iss_free[FU_ADDR])
   );

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////
   function automatic string unit_label(input int u);
      case (u)
         FU_MULT: return "mul";
         FU_ALU1: return "alu1";
         FU_ALU2: return "alu2";
         default: return "adr";
      endcase
   endfunction

   task automatic log_error(input string msg);
      err_cnt++;
      test_err++;
      $display("[ERROR] %0t ns: %s", $time, msg);
   endtask

   // rows past the end of the file drive an idle cycle
   task automatic drive_row(input int r);
      int b;
      b = r * NFIELD;
      if (r < npat)
      begin
         dispatch_vld <= pat_mem[b+F_DV][0];
         opcls        <= pat_mem[b+F_OPC][OPC_BITS-1:0];
         psrc1        <= pat_mem[b+F_PS1][PREG_BITS-1:0];
         psrc2        <= pat_mem[b+F_PS2][PREG_BITS-1:0];
         pdest        <= pat_mem[b+F_PD][PREG_BITS-1:0];
         ctrl         <= pat_mem[b+F_CTRL][CTRL_BITS-1:0];
         free_preg    <= pat_mem[b+F_FP][PREG_BITS-1:0];
         wb_vld       <= pat_mem[b+F_WBV][0];
         wb_preg      <= pat_mem[b+F_WBP][PREG_BITS-1:0];
         // bit 4 of the fu column asks for a random unit mask
         if (pat_mem[b+F_FU][4])
            fu_rdy <= FU_NUM'($urandom);
         else
            fu_rdy <= pat_mem[b+F_FU][FU_NUM-1:0];
         if (pat_mem[b+F_DV][0])
         begin
            rec_psrc1[pat_mem[b+F_PD][PREG_BITS-1:0]] = pat_mem[b+F_PS1][PREG_BITS-1:0];
            rec_psrc2[pat_mem[b+F_PD][PREG_BITS-1:0]] = pat_mem[b+F_PS2][PREG_BITS-1:0];
            rec_ctrl[pat_mem[b+F_PD][PREG_BITS-1:0]]  = pat_mem[b+F_CTRL][CTRL_BITS-1:0];
            rec_free[pat_mem[b+F_PD][PREG_BITS-1:0]]  = pat_mem[b+F_FP][PREG_BITS-1:0];
         end
      end
      else
      begin
         dispatch_vld <= 1'b0;
         wb_vld       <= 1'b0;
         fu_rdy       <= '0;
      end
   endtask

   // expected outputs of row r show up two cycles after it was driven
   task automatic check_row(input int r);
      int b;
      int e;
      logic [PREG_BITS-1:0] pd;
      b = r * NFIELD;
      for (int u = 0; u < FU_NUM; u++)
      begin
         e = b + F_EXP + 3 * u;
         assert (iss_vld[u] === pat_mem[e][0])
         else log_error($sformatf("row %0d %s valid is %b, expected %b",
                                  r, unit_label(u), iss_vld[u], pat_mem[e][0]));
         if (iss_vld[u] === 1'b1 && pat_mem[e][0])
         begin
            pd = pat_mem[e+2][PREG_BITS-1:0];
            assert (int'(iss_idx[u]) == int'(pat_mem[e+1]))
            else log_error($sformatf("row %0d %s slot is %0d, expected %0d",
                                     r, unit_label(u), iss_idx[u], pat_mem[e+1]));
            assert (int'(iss_pdest[u]) == int'(pat_mem[e+2]))
            else log_error($sformatf("row %0d %s pdest is %h, expected %h",
                                     r, unit_label(u), iss_pdest[u], pat_mem[e+2]));
            // remaining payload must match what was dispatched with that pdest
            assert (iss_psrc1[u] === rec_psrc1[pd] && iss_psrc2[u] === rec_psrc2[pd]
                    && iss_ctrl[u] === rec_ctrl[pd] && iss_free[u] === rec_free[pd])
            else log_error($sformatf("row %0d %s payload of pdest %h differs from dispatch",
                                     r, unit_label(u), pd));
         end
      end
      assert (full === pat_mem[b+F_FULL][0])
      else log_error($sformatf("row %0d full is %b, expected %b",
                               r, full, pat_mem[b+F_FULL][0]));
      row_cnt++;
      test_rows++;
   endtask

   //////////////////////////////////////////////////
   // timeout
   //////////////////////////////////////////////////
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("timeout: the run did not end within %0d cycles", cycle_limit);
         $display("Test FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial
   begin
      void'($urandom(4));
      rst          = 1'b1;
      dispatch_vld = 1'b0;
      opcls        = '0;
      psrc1        = '0;
      psrc2        = '0;
      pdest        = '0;
      ctrl         = '0;
      free_preg    = '0;
      wb_vld       = 1'b0;
      wb_preg      = '0;
      fu_rdy       = '0;

      // unread words keep this marker and it ends the row count
      for (int i = 0; i < PAT_MAX * NFIELD; i++)
         pat_mem[i] = 9'h1ff;
      $readmemh("verification/issue_patterns.txt", pat_mem);
      npat = 0;
      while (npat < PAT_MAX && pat_mem[npat*NFIELD] !== 9'h1ff)
         npat++;
      if (npat == 0)
      begin
         $display("pattern file could not be read or holds no rows");
         err_cnt++;
      end
      cycle_limit = npat + 20;

      repeat (2) @(posedge clk);
      rst <= 1'b0;

      // two extra idle cycles flush the last expected rows
      for (int k = 0; k < npat + 2; k++)
      begin
         @(posedge clk);
         drive_row(k);
         @(negedge clk);
         if (k >= 2)
         begin
            check_row(k - 2);
            if (k - 2 == npat - 1 || pat_mem[(k-1)*NFIELD] != pat_mem[(k-2)*NFIELD])
            begin
               $display("test %0d done: %0d rows, %0d errors",
                        pat_mem[(k-2)*NFIELD], test_rows, test_err);
               test_cnt++;
               test_rows = 0;
               test_err  = 0;
            end
         end
      end

      $display("%0d tests, %0d rows checked, %0d errors", test_cnt, row_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD_NS = 100
)
(
   output logic clk_o
);

   // free running clock, first rising edge half a period in
   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #(PERIOD_NS / 2);
         clk_o = ~clk_o;
      end
   end

endmodule

/* hdl/issue_stage_top.sv */
`timescale 1ns/1ns

module issue_stage_top #(
   parameter int ISQ_DEPTH = 8
)
(
   input  logic                              clk_i,
   input  logic                              rst_i,
   // dispatch
   input  logic                              dispatch_vld_i,
   input  logic [issue_pkg::OPC_BITS-1:0]    opcls_i,
   input  logic [issue_pkg::PREG_BITS-1:0]   psrc1_i,
   input  logic [issue_pkg::PREG_BITS-1:0]   psrc2_i,
   input  logic [issue_pkg::PREG_BITS-1:0]   pdest_i,
   input  logic [issue_pkg::CTRL_BITS-1:0]   ctrl_i,
   input  logic [issue_pkg::PREG_BITS-1:0]   free_preg_i,
   // writeback and unit status
   input  logic                              wb_vld_i,
   input  logic [issue_pkg::PREG_BITS-1:0]   wb_preg_i,
   input  logic [issue_pkg::FU_NUM-1:0]      fu_rdy_i,
   output logic                              full_o,
   // issue ports
   output logic                              mul_vld_o,
   output logic [$clog2(ISQ_DEPTH)-1:0]      mul_idx_o,
   output logic [issue_pkg::PREG_BITS-1:0]   mul_psrc1_o,
   output logic [issue_pkg::PREG_BITS-1:0]   mul_psrc2_o,
   output logic [issue_pkg::PREG_BITS-1:0]   mul_pdest_o,
   output logic [issue_pkg::CTRL_BITS-1:0]   mul_ctrl_o,
   output logic [issue_pkg::PREG_BITS-1:0]   mul_free_preg_o,
   output logic                              alu1_vld_o,
   output logic [$clog2(ISQ_DEPTH)-1:0]      alu1_idx_o,
   output logic [issue_pkg::PREG_BITS-1:0]   alu1_psrc1_o,
   output logic [issue_pkg::PREG_BITS-1:0]   alu1_psrc2_o,
   output logic [issue_pkg::PREG_BITS-1:0]   alu1_pdest_o,
   output logic [issue_pkg::CTRL_BITS-1:0]   alu1_ctrl_o,
   output logic [issue_pkg::PREG_BITS-1:0]   alu1_free_preg_o,
   output logic                              alu2_vld_o,
   output logic [$clog2(ISQ_DEPTH)-1:0]      alu2_idx_o,
   output logic [issue_pkg::PREG_BITS-1:0]   alu2_psrc1_o,
   output logic [issue_pkg::PREG_BITS-1:0]   alu2_psrc2_o,
   output logic [issue_pkg::PREG_BITS-1:0]   alu2_pdest_o,
   output logic [issue_pkg::CTRL_BITS-1:0]   alu2_ctrl_o,
   output logic [issue_pkg::PREG_BITS-1:0]   alu2_free_preg_o,
   output logic                              adr_vld_o,
   output logic [$clog2(ISQ_DEPTH)-1:0]      adr_idx_o,
   output logic [issue_pkg::PREG_BITS-1:0]   adr_psrc1_o,
   output logic [issue_pkg::PREG_BITS-1:0]   adr_psrc2_o,
   output logic [issue_pkg::PREG_BITS-1:0]   adr_pdest_o,
   output logic [issue_pkg::CTRL_BITS-1:0]   adr_ctrl_o,
   output logic [issue_pkg::PREG_BITS-1:0]   adr_free_preg_o
);
   import issue_pkg::*;

   // queue entry fields, flat per slot
   logic [ISQ_DEPTH-1:0]           ent_vld;
   logic [ISQ_DEPTH*OPC_BITS-1:0]  ent_opcls;
   logic [ISQ_DEPTH*PREG_BITS-1:0] ent_psrc1;
   logic [ISQ_DEPTH*PREG_BITS-1:0] ent_psrc2;
   logic [ISQ_DEPTH*PREG_BITS-1:0] ent_pdest;
   logic [ISQ_DEPTH*CTRL_BITS-1:0] ent_ctrl;
   logic [ISQ_DEPTH*PREG_BITS-1:0] ent_free_preg;
   // scoreboard and selector handshakes
   logic [ISQ_DEPTH-1:0]           src_rdy;
   logic [ISQ_DEPTH-1:0]           release_mask;
   logic                           alloc_strobe;
   logic [PREG_BITS-1:0]           alloc_pdest;

   //////////////////////////////////////////////////
   // queue and scoreboard side by side
   //////////////////////////////////////////////////
   issue_queue #(.ISQ_DEPTH(ISQ_DEPTH)) u_queue (
      .*,
      .release_i       (release_mask),
      .ent_vld_o       (ent_vld),
      .ent_opcls_o     (ent_opcls),
      .ent_psrc1_o     (ent_psrc1),
      .ent_psrc2_o     (ent_psrc2),
      .ent_pdest_o     (ent_pdest),
      .ent_ctrl_o      (ent_ctrl),
      .ent_free_preg_o (ent_free_preg),
      .alloc_strobe_o  (alloc_strobe),
      .alloc_pdest_o   (alloc_pdest)
   );

   // newly dispatched pdest goes not-ready at the write edge
   operand_scoreboard #(.ISQ_DEPTH(ISQ_DEPTH)) u_scoreboard (
      .*,
      .alloc_strobe_i (alloc_strobe),
      .alloc_pdest_i  (alloc_pdest),
      .ent_psrc1_i    (ent_psrc1),
      .ent_psrc2_i    (ent_psrc2),
      .src_rdy_o      (src_rdy)
   );

   // selector, issue ports go straight out
   issue_select #(.ISQ_DEPTH(ISQ_DEPTH)) u_select (
      .*,
      .ent_vld_i       (ent_vld),
      .ent_opcls_i     (ent_opcls),
      .ent_psrc1_i     (ent_psrc1),
      .ent_psrc2_i     (ent_psrc2),
      .ent_pdest_i     (ent_pdest),
      .ent_ctrl_i      (ent_ctrl),
      .ent_free_preg_i (ent_free_preg),
      .src_rdy_i       (src_rdy),
      .release_o       (release_mask)
   );

endmodule

/* hdl/issue_select.sv */
`timescale 1ns/1ns

module issue_select #(
   parameter int ISQ_DEPTH = 8
)
(
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic [issue_pkg::FU_NUM-1:0]             fu_rdy_i,
   input  logic [ISQ_DEPTH-1:0]                     ent_vld_i,
   input  logic [ISQ_DEPTH*issue_pkg::OPC_BITS-1:0]  ent_opcls_i,
   input  logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_psrc1_i,
   input  logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_psrc2_i,
   input  logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_pdest_i,
   input  logic [ISQ_DEPTH*issue_pkg::CTRL_BITS-1:0] ent_ctrl_i,
   input  logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_free_preg_i,
   input  logic [ISQ_DEPTH-1:0]                     src_rdy_i,
   output logic [ISQ_DEPTH-1:0]                     release_o,
   // multiplier
   output logic                                     mul_vld_o,
   output logic [$clog2(ISQ_DEPTH)-1:0]             mul_idx_o,
   output logic [issue_pkg::PREG_BITS-1:0]          mul_psrc1_o,
   output logic [issue_pkg::PREG_BITS-1:0]          mul_psrc2_o,
   output logic [issue_pkg::PREG_BITS-1:0]          mul_pdest_o,
   output logic [issue_pkg::CTRL_BITS-1:0]          mul_ctrl_o,
   output logic [issue_pkg::PREG_BITS-1:0]          mul_free_preg_o,
   // alu 1
   output logic                                     alu1_vld_o,
   output logic [$clog2(ISQ_DEPTH)-1:0]             alu1_idx_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alu1_psrc1_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alu1_psrc2_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alu1_pdest_o,
   output logic [issue_pkg::CTRL_BITS-1:0]          alu1_ctrl_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alu1_free_preg_o,
   // alu 2
   output logic                                     alu2_vld_o,
   output logic [$clog2(ISQ_DEPTH)-1:0]             alu2_idx_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alu2_psrc1_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alu2_psrc2_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alu2_pdest_o,
   output logic [issue_pkg::CTRL_BITS-1:0]          alu2_ctrl_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alu2_free_preg_o,
   // address adder
   output logic                                     adr_vld_o,
   output logic [$clog2(ISQ_DEPTH)-1:0]             adr_idx_o,
   output logic [issue_pkg::PREG_BITS-1:0]          adr_psrc1_o,
   output logic [issue_pkg::PREG_BITS-1:0]          adr_psrc2_o,
   output logic [issue_pkg::PREG_BITS-1:0]          adr_pdest_o,
   output logic [issue_pkg::CTRL_BITS-1:0]          adr_ctrl_o,
   output logic [issue_pkg::PREG_BITS-1:0]          adr_free_preg_o
);
   import issue_pkg::*;

   localparam int IDX_BITS = $clog2(ISQ_DEPTH);
   localparam int ISS_W    = ISSUE_WIDTH(ISQ_DEPTH);

   wire  [FU_NUM-1:0][ISQ_DEPTH-1:0] elig;
   logic [FU_NUM-1:0][ISQ_DEPTH-1:0] pick_oh;
   logic [ISS_W-1:0]                 iss_d [FU_NUM];
   logic [FU_NUM-1:0]                iss_vld_q;
   logic [ISS_W-2:0]                 iss_pay_q [FU_NUM];

   //////////////////////////////////////////////////
   // per unit eligibility
   //////////////////////////////////////////////////
   for (genvar s = 0; s < ISQ_DEPTH; s++)
   begin : g_elig
      // adds split by slot, every third slot goes to alu 1
      localparam bit ADD_ON_ALU1 = (s % 3) == 0;
      logic [OPC_BITS-1:0] opc;
      logic                base;

      assign opc  = ent_opcls_i[s*OPC_BITS +: OPC_BITS];
      assign base = ent_vld_i[s] & src_rdy_i[s];

      assign elig[FU_MULT][s] = base & fu_rdy_i[FU_MULT] & (opc == OPC_MULT);
      // branches only ever use alu 1
      assign elig[FU_ALU1][s] = base & fu_rdy_i[FU_ALU1]
                              & ((opc == OPC_BR) | ((opc == OPC_ADD) & ADD_ON_ALU1));
      assign elig[FU_ALU2][s] = base & fu_rdy_i[FU_ALU2] & (opc == OPC_ADD) & !ADD_ON_ALU1;
      assign elig[FU_ADDR][s] = base & fu_rdy_i[FU_ADDR] & (opc == OPC_ADDR);
   end

   //////////////////////////////////////////////////
   // priority pick, lowest slot wins
   //////////////////////////////////////////////////
   always_comb
   begin
      release_o = '0;
      for (int u = 0; u < FU_NUM; u++)
      begin
         pick_oh[u] = '0;
         iss_d[u]   = '0;
         // scan downward, last hit is the lowest eligible slot
         for (int s = ISQ_DEPTH - 1; s >= 0; s--)
         begin
            if (elig[u][s])
            begin
               pick_oh[u] = ISQ_DEPTH'(1) << s;
               // reordered issue word: vld | idx | psrc1 | psrc2 | pdest | ctrl | free preg
               iss_d[u] = {1'b1, IDX_BITS'(s),
                           ent_psrc1_i[s*PREG_BITS +: PREG_BITS],
                           ent_psrc2_i[s*PREG_BITS +: PREG_BITS],
                           ent_pdest_i[s*PREG_BITS +: PREG_BITS],
                           ent_ctrl_i[s*CTRL_BITS +: CTRL_BITS],
                           ent_free_preg_i[s*PREG_BITS +: PREG_BITS]};
            end
         end
         // a slot is picked by at most one unit, classes are disjoint
         release_o = release_o | pick_oh[u];
      end
   end

   // issue registers, valid strobes for one cycle
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         iss_vld_q <= '0;
      else
      begin
         for (int u = 0; u < FU_NUM; u++)
            iss_vld_q[u] <= iss_d[u][ISS_W-1];
      end
   end

   always_ff @(posedge clk_i)
   begin
      for (int u = 0; u < FU_NUM; u++)
         iss_pay_q[u] <= iss_d[u][ISS_W-2:0];
   end

   //////////////////////////////////////////////////
   // unpack to the unit ports
   //////////////////////////////////////////////////
   assign {mul_vld_o, mul_idx_o, mul_psrc1_o, mul_psrc2_o, mul_pdest_o, mul_ctrl_o,
           mul_free_preg_o} = {iss_vld_q[FU_MULT], iss_pay_q[FU_MULT]};
   assign {alu1_vld_o, alu1_idx_o, alu1_psrc1_o, alu1_psrc2_o, alu1_pdest_o, alu1_ctrl_o,
           alu1_free_preg_o} = {iss_vld_q[FU_ALU1], iss_pay_q[FU_ALU1]};
   assign {alu2_vld_o, alu2_idx_o, alu2_psrc1_o, alu2_psrc2_o, alu2_pdest_o, alu2_ctrl_o,
           alu2_free_preg_o} = {iss_vld_q[FU_ALU2], iss_pay_q[FU_ALU2]};
   assign {adr_vld_o, adr_idx_o, adr_psrc1_o, adr_psrc2_o, adr_pdest_o, adr_ctrl_o,
           adr_free_preg_o} = {iss_vld_q[FU_ADDR], iss_pay_q[FU_ADDR]};

endmodule

/* hdl/operand_scoreboard.sv */
`timescale 1ns/1ns

module operand_scoreboard #(
   parameter int ISQ_DEPTH = 8
)
(
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic                                     alloc_strobe_i,
   input  logic [issue_pkg::PREG_BITS-1:0]          alloc_pdest_i,
   input  logic                                     wb_vld_i,
   input  logic [issue_pkg::PREG_BITS-1:0]          wb_preg_i,
   input  logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_psrc1_i,
   input  logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_psrc2_i,
   output logic [ISQ_DEPTH-1:0]                     src_rdy_o
);
   import issue_pkg::*;

   // one ready bit per physical register
   logic [PREG_NUM-1:0] preg_rdy_q;

   //////////////////////////////////////////////////
   // ready bit update
   //////////////////////////////////////////////////
   // all registers hold committed values out of reset
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         preg_rdy_q <= '1;
      else
      begin
         // writeback wakes the register up
         if (wb_vld_i)
            preg_rdy_q[wb_preg_i] <= 1'b1;
         // new producer clears it, written last so dispatch wins on a clash
         if (alloc_strobe_i)
            preg_rdy_q[alloc_pdest_i] <= 1'b0;
      end
   end

   // per slot lookup of both sources
   // invalid slots give don't care, the selector masks them with the valid bit
   for (genvar s = 0; s < ISQ_DEPTH; s++)
   begin : g_lookup
      assign src_rdy_o[s] = preg_rdy_q[ent_psrc1_i[s*PREG_BITS +: PREG_BITS]]
                          & preg_rdy_q[ent_psrc2_i[s*PREG_BITS +: PREG_BITS]];
   end

endmodule

/* hdl/issue_queue.sv */
`timescale 1ns/1ns

module issue_queue #(
   parameter int ISQ_DEPTH = 8
)
(
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic                                     dispatch_vld_i,
   input  logic [issue_pkg::OPC_BITS-1:0]           opcls_i,
   input  logic [issue_pkg::PREG_BITS-1:0]          psrc1_i,
   input  logic [issue_pkg::PREG_BITS-1:0]          psrc2_i,
   input  logic [issue_pkg::PREG_BITS-1:0]          pdest_i,
   input  logic [issue_pkg::CTRL_BITS-1:0]          ctrl_i,
   input  logic [issue_pkg::PREG_BITS-1:0]          free_preg_i,
   input  logic [ISQ_DEPTH-1:0]                     release_i,
   output logic [ISQ_DEPTH-1:0]                     ent_vld_o,
   output logic [ISQ_DEPTH*issue_pkg::OPC_BITS-1:0]  ent_opcls_o,
   output logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_psrc1_o,
   output logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_psrc2_o,
   output logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_pdest_o,
   output logic [ISQ_DEPTH*issue_pkg::CTRL_BITS-1:0] ent_ctrl_o,
   output logic [ISQ_DEPTH*issue_pkg::PREG_BITS-1:0] ent_free_preg_o,
   output logic                                     alloc_strobe_o,
   output logic [issue_pkg::PREG_BITS-1:0]          alloc_pdest_o,
   output logic                                     full_o
);
   import issue_pkg::*;

   localparam int IDX_BITS = $clog2(ISQ_DEPTH);

   // valid bit per slot, payload kept without reset
   logic [ISQ_DEPTH-1:0] vld_q;
   logic [ENT_BITS-1:0]  ent_q [ISQ_DEPTH];
   logic [IDX_BITS-1:0]  alloc_idx;
   logic [ISQ_DEPTH-1:0] alloc_oh;

   assign full_o         = &vld_q;
   // a dispatch while full is dropped
   assign alloc_strobe_o = dispatch_vld_i & ~full_o;
   assign alloc_pdest_o  = pdest_i;
   assign ent_vld_o      = vld_q;

   //////////////////////////////////////////////////
   // lowest free slot
   //////////////////////////////////////////////////
   always_comb
   begin
      alloc_idx = '0;
      // walk down so the lowest free slot is the one kept
      for (int s = ISQ_DEPTH - 1; s >= 0; s--)
      begin
         if (!vld_q[s])
            alloc_idx = IDX_BITS'(s);
      end
      alloc_oh = alloc_strobe_o ? (ISQ_DEPTH'(1) << alloc_idx) : '0;
   end

   // released slots only become free on the following cycle
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         vld_q <= '0;
      else
         vld_q <= (vld_q & ~release_i) | alloc_oh;
   end

   always_ff @(posedge clk_i)
   begin
      if (alloc_strobe_o)
         ent_q[alloc_idx] <= {opcls_i, psrc1_i, psrc2_i, pdest_i, ctrl_i, free_preg_i};
   end

   //////////////////////////////////////////////////
   // flatten entry fields for scoreboard and selector
   //////////////////////////////////////////////////
   for (genvar s = 0; s < ISQ_DEPTH; s++)
   begin : g_ent
      assign ent_opcls_o[s*OPC_BITS +: OPC_BITS]       = ent_q[s][ENT_OPC_LSB +: OPC_BITS];
      assign ent_psrc1_o[s*PREG_BITS +: PREG_BITS]     = ent_q[s][ENT_PSRC1_LSB +: PREG_BITS];
      assign ent_psrc2_o[s*PREG_BITS +: PREG_BITS]     = ent_q[s][ENT_PSRC2_LSB +: PREG_BITS];
      assign ent_pdest_o[s*PREG_BITS +: PREG_BITS]     = ent_q[s][ENT_PDEST_LSB +: PREG_BITS];
      assign ent_ctrl_o[s*CTRL_BITS +: CTRL_BITS]      = ent_q[s][ENT_CTRL_LSB +: CTRL_BITS];
      assign ent_free_preg_o[s*PREG_BITS +: PREG_BITS] = ent_q[s][ENT_FREE_LSB +: PREG_BITS];
   end

endmodule

/* hdl/issue_pkg.sv */
package issue_pkg;

   //////////////////////////////////////////////////
   // physical registers and control field
   //////////////////////////////////////////////////
   localparam int PREG_BITS = 6;
   // one ready bit per physical register
   localparam int PREG_NUM  = 1 << PREG_BITS;
   localparam int CTRL_BITS = 8;

   // bit of each function unit in fu_rdy and the per-unit vectors
   localparam int FU_NUM  = 4;
   localparam int FU_MULT = 0;
   localparam int FU_ALU1 = 1;
   localparam int FU_ALU2 = 2;
   localparam int FU_ADDR = 3;

   // op class carried with every dispatched instruction
   localparam int OPC_BITS = 2;
   localparam logic [OPC_BITS-1:0] OPC_MULT = 2'd0;
   localparam logic [OPC_BITS-1:0] OPC_ADD  = 2'd1;
   localparam logic [OPC_BITS-1:0] OPC_BR   = 2'd2;
   localparam logic [OPC_BITS-1:0] OPC_ADDR = 2'd3;

   //////////////////////////////////////////////////
   // queue entry layout
   //////////////////////////////////////////////////
   // opcls | psrc1 | psrc2 | pdest | ctrl | free preg
   // everything below opcls is the issue payload, same order as on the issue ports
   localparam int ENT_FREE_LSB  = 0;
   localparam int ENT_CTRL_LSB  = ENT_FREE_LSB + PREG_BITS;
   localparam int ENT_PDEST_LSB = ENT_CTRL_LSB + CTRL_BITS;
   localparam int ENT_PSRC2_LSB = ENT_PDEST_LSB + PREG_BITS;
   localparam int ENT_PSRC1_LSB = ENT_PSRC2_LSB + PREG_BITS;
   localparam int ENT_PAY_BITS  = ENT_PSRC1_LSB + PREG_BITS;
   localparam int ENT_OPC_LSB   = ENT_PAY_BITS;
   localparam int ENT_BITS      = ENT_OPC_LSB + OPC_BITS;

   // issued instruction: valid | slot idx | payload
   // slot idx width depends on the queue depth
   function automatic int ISSUE_WIDTH(int depth);
      return 1 + $clog2(depth) + ENT_PAY_BITS;
   endfunction

endpackage
